// File: design/roundPkg.sv
package roundPkg;

    //////////////////////////////////////////////////
    // format widths
    //////////////////////////////////////////////////

    localparam int EXP_W   = 11;              // double exponent width
    localparam int FRAC_W  = 52;              // double fraction width
    localparam int FRAC1_W = 23;              // single fraction width

    // shifter output, two full significands plus rounding bits
    localparam int SHIFT_W = 2*FRAC_W + 4;    // 108

    // exponent with overflow and sign bits on top of the fraction
    localparam int ADD_W   = EXP_W + 2 + FRAC_W;   // 65

    //////////////////////////////////////////////////
    // bit positions in the shifted significand
    //////////////////////////////////////////////////

    // the result lsb sits right under the kept fraction
    localparam int LSB_POS_D = SHIFT_W - FRAC_W;   // 56
    localparam int LSB_POS_S = SHIFT_W - FRAC1_W;  // 85
    // round bit is LSB_POS-1 and guard bit is LSB_POS-2

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    typedef logic [EXP_W-1:0]   expT;        // plain exponent
    typedef logic [EXP_W+1:0]   expExtT;     // exponent + overflow + sign
    typedef logic [FRAC_W-1:0]  fracT;       // double fraction
    typedef logic [SHIFT_W-1:0] shiftT;      // normalized significand
    typedef logic [ADD_W-1:0]   addT;        // rounding addend / exp-frac word

    // output precision
    // 1 selects double, 0 selects single
    typedef logic fmtT;

    //////////////////////////////////////////////////
    // rounding modes, riscv frm encoding
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        RNE = 3'd0,   // to nearest, ties to even
        RTZ = 3'd1,   // toward zero
        RDN = 3'd2,   // toward -inf
        RUP = 3'd3,   // toward +inf
        RMM = 3'd4    // to nearest, ties to max magnitude
    } roundModeT;

endpackage

// File: design/roundInputStage.sv
`timescale 1ns/100ps

module roundInputStage import roundPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,         // one strobe per operation
    input  fmtT       outFmt,          // 1 double, 0 single
    input  roundModeT roundMode,
    input  logic      fmaOp,
    input  logic      divOp,
    input  shiftT     corrShifted,     // normalized significand
    input  logic      addendSticky,    // sticky of the shifted-out addend
    input  logic      zZero,           // addend is zero
    input  logic      invZ,            // addend is subtracted
    input  expExtT    sumExp,          // fma exponent
    input  expExtT    divExp,          // divide exponent
    input  logic      divSticky,
    input  logic      divNegSticky,
    input  logic      roundSgn,        // sign of the result
    output logic      stValid,
    output fmtT       stFmt,
    output roundModeT stMode,
    output logic      stFma,
    output logic      stDiv,
    output logic      stAddendSticky,
    output logic      stZZero,
    output logic      stInvZ,
    output expExtT    stSumExp,
    output expExtT    stDivExp,
    output logic      stDivSticky,
    output logic      stDivNegSticky,
    output logic      stSgn,
    output fracT      stFrac,          // fraction before rounding
    output logic      roundBit,
    output logic      guardBit,
    output logic      lsbBit,
    output logic      normSticky       // or of everything below guard
);

    shiftT stShift;        // captured significand
    logic  lowSticky;      // below the double guard bit
    logic  midSticky;      // between single and double guard bits

    //////////////////////////////////////////////////
    // input register
    //////////////////////////////////////////////////

    // valid strobe, cleared on reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stValid <= 1'b0;
        end else begin
            stValid <= inValid;
        end
    end

    // operation fields only move with a new operation
    always_ff @(posedge clk) begin
        if (inValid) begin
            stFmt          <= outFmt;
            stMode         <= roundMode;
            stFma          <= fmaOp;
            stDiv          <= divOp;
            stShift        <= corrShifted;
            stAddendSticky <= addendSticky;
            stZZero        <= zZero;
            stInvZ         <= invZ;
            stSumExp       <= sumExp;
            stDivExp       <= divExp;
            stDivSticky    <= divSticky;
            stDivNegSticky <= divNegSticky;
            stSgn          <= roundSgn;
        end
    end

    //////////////////////////////////////////////////
    // rounding bit extraction
    //////////////////////////////////////////////////

    // kept fraction is the top of the shifter output
    assign stFrac = stShift[SHIFT_W-1 -: FRAC_W];

    // lsb / round / guard at the selected precision
    assign lsbBit   = stFmt ? stShift[LSB_POS_D]   : stShift[LSB_POS_S];
    assign roundBit = stFmt ? stShift[LSB_POS_D-1] : stShift[LSB_POS_S-1];
    assign guardBit = stFmt ? stShift[LSB_POS_D-2] : stShift[LSB_POS_S-2];

    // sticky region grows downward from the guard bit
    assign lowSticky = |stShift[LSB_POS_D-3:0];
    assign midSticky = |stShift[LSB_POS_S-3:LSB_POS_D-2];   // single only

    // single also folds in the double round/guard/lsb span
    assign normSticky = lowSticky | (midSticky & ~stFmt);

endmodule

// File: design/roundDecision.sv
`timescale 1ns/100ps

module roundDecision import roundPkg::*; (
    input  fmtT       stFmt,
    input  roundModeT stMode,
    input  logic      stFma,
    input  logic      stDiv,
    input  logic      stAddendSticky,
    input  logic      stZZero,
    input  logic      stInvZ,
    input  logic      sumOvf,           // top bit of the fma sum exponent
    input  logic      stDivSticky,
    input  logic      stDivNegSticky,
    input  logic      stSgn,            // 1 for a negative result
    input  logic      roundBit,
    input  logic      guardBit,
    input  logic      lsbBit,
    input  logic      normSticky,
    output logic      sticky,
    output logic      plus1,            // add one ulp
    output addT       roundAdd          // value added to {exp, frac}
);

    logic subSmall;       // a tiny value was meant to be subtracted
    logic calcPlus1;
    logic calcMinus1;
    logic minus1;         // subtract one ulp
    logic inexact;

    //////////////////////////////////////////////////
    // sticky and small subtraction
    //////////////////////////////////////////////////

    // addend sticky and exponent overflow only count for fma
    assign sticky = (stAddendSticky & stFma) | (sumOvf & stFma) |
                    (stDivSticky & stDiv) | normSticky | guardBit;

    // the small number only shows if nothing else sits below round
    assign subSmall = ((stAddendSticky & stFma & ~stZZero & stInvZ) |
                       (stDivNegSticky & stDiv)) & ~(normSticky | guardBit);

    //////////////////////////////////////////////////
    // per-mode decision
    //////////////////////////////////////////////////

    always_comb begin
        calcPlus1  = 1'b0;
        calcMinus1 = 1'b0;
        case (stMode)
            RNE: calcPlus1 = roundBit & (sticky | lsbBit) & ~subSmall;   // tie goes to even
            RTZ: calcMinus1 = subSmall & ~roundBit;
            RDN: begin
                calcPlus1  = stSgn & ~(subSmall & ~roundBit);     // grow magnitude when negative
                calcMinus1 = ~stSgn & subSmall & ~roundBit;
            end
            RUP: begin
                calcPlus1  = ~stSgn & ~(subSmall & ~roundBit);    // grow magnitude when positive
                calcMinus1 = stSgn & subSmall & ~roundBit;
            end
            RMM: calcPlus1 = roundBit & ~subSmall;                // tie goes away from zero
            default: begin
                calcPlus1  = 1'b0;    // reserved encodings leave the value alone
                calcMinus1 = 1'b0;
            end
        endcase
    end

    // exact results are never rounded
    assign inexact = sticky | roundBit;
    assign plus1   = calcPlus1 & inexact;
    assign minus1  = calcMinus1 & inexact;

    //////////////////////////////////////////////////
    // addend at the format lsb
    //////////////////////////////////////////////////

    // {exp(EXP_W+2), frac(FRAC_W)}, single lsb sits FRAC_W-FRAC1_W up
    always_comb begin
        if (minus1) begin
            if (stFmt) roundAdd = '1;                          // -1 at bit 0
            else       roundAdd = {{(EXP_W+2+FRAC1_W){1'b1}}, {(FRAC_W-FRAC1_W){1'b0}}};
        end else if (plus1) begin
            if (stFmt) roundAdd = addT'(1);
            else       roundAdd = addT'(1) << (FRAC_W-FRAC1_W);
        end else begin
            roundAdd = '0;
        end
    end

endmodule

// File: design/roundOutputStage.sv
`timescale 1ns/100ps

module roundOutputStage import roundPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   stValid,
    input  logic   stDiv,         // pick the divide exponent
    input  expExtT stSumExp,
    input  expExtT stDivExp,
    input  fracT   stFrac,
    input  addT    roundAdd,
    input  logic   sticky,
    input  logic   plus1,
    output logic   outValid,
    output fracT   resFrac,
    output expT    resExp,
    output expExtT fullResExp,    // keeps overflow and sign bits
    output logic   stickyOut,
    output logic   plus1Out
);

    expExtT roundExp;       // exponent going into the adder
    expExtT sumExpNext;
    fracT   sumFracNext;

    //////////////////////////////////////////////////
    // rounding adder
    //////////////////////////////////////////////////

    // fma and divide have their own exponent paths
    assign roundExp = stDiv ? stDivExp : stSumExp;

    // fraction carry runs straight into the exponent
    assign {sumExpNext, sumFracNext} = {roundExp, stFrac} + roundAdd;

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid   <= 1'b0;
            fullResExp <= '0;
            resExp     <= '0;
            resFrac    <= '0;
            stickyOut  <= 1'b0;
            plus1Out   <= 1'b0;
        end else begin
            outValid <= stValid;
            if (stValid) begin                            // hold otherwise
                fullResExp <= sumExpNext;
                resExp     <= sumExpNext[EXP_W-1:0];   // drop overflow/sign
                resFrac    <= sumFracNext;
                stickyOut  <= sticky;
                plus1Out   <= plus1;
            end
        end
    end

endmodule

// File: design/fpRound.sv
`timescale 1ns/100ps

module fpRound import roundPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,
    input  fmtT       outFmt,
    input  roundModeT roundMode,
    input  logic      fmaOp,
    input  logic      divOp,
    input  shiftT     corrShifted,
    input  logic      addendSticky,
    input  logic      zZero,
    input  logic      invZ,
    input  expExtT    sumExp,
    input  expExtT    divExp,
    input  logic      divSticky,
    input  logic      divNegSticky,
    input  logic      roundSgn,
    output logic      outValid,
    output fracT      resFrac,
    output expT       resExp,
    output expExtT    fullResExp,
    output logic      sticky,
    output logic      plus1
);

    // registered operation
    logic      stValid;
    fmtT       stFmt;
    roundModeT stMode;
    logic      stFma, stDiv;
    logic      stAddendSticky, stZZero, stInvZ;
    expExtT    stSumExp, stDivExp;
    logic      stDivSticky, stDivNegSticky;
    logic      stSgn;
    fracT      stFrac;
    logic      roundBit, guardBit, lsbBit, normSticky;

    // decision results
    logic      decSticky, decPlus1;
    addT       roundAdd;

    //////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////

    roundInputStage inStage_i (
        .clk, .rstN, .inValid, .outFmt, .roundMode, .fmaOp, .divOp,
        .corrShifted, .addendSticky, .zZero, .invZ, .sumExp, .divExp,
        .divSticky, .divNegSticky, .roundSgn,
        .stValid, .stFmt, .stMode, .stFma, .stDiv, .stAddendSticky,
        .stZZero, .stInvZ, .stSumExp, .stDivExp, .stDivSticky,
        .stDivNegSticky, .stSgn, .stFrac,
        .roundBit, .guardBit, .lsbBit, .normSticky
    );

    roundDecision decide_i (
        .stFmt, .stMode, .stFma, .stDiv, .stAddendSticky, .stZZero, .stInvZ,
        .sumOvf   (stSumExp[EXP_W+1]),   // overflow bit of the fma exponent
        .stDivSticky, .stDivNegSticky, .stSgn,
        .roundBit, .guardBit, .lsbBit, .normSticky,
        .sticky   (decSticky),
        .plus1    (decPlus1),
        .roundAdd
    );

    roundOutputStage outStage_i (
        .clk, .rstN, .stValid, .stDiv, .stSumExp, .stDivExp, .stFrac,
        .roundAdd,
        .sticky    (decSticky),
        .plus1     (decPlus1),
        .outValid, .resFrac, .resExp, .fullResExp,
        .stickyOut (sticky),
        .plus1Out  (plus1)
    );

endmodule

// File: verif/fpRound_sva.sv
`timescale 1ns/100ps

module fpRoundSva (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  logic outValid
);

    //////////////////////////////////////////////////
    // reset behavior
    //////////////////////////////////////////////////

    // output strobe is held off while reset is active
    property outQuietInReset;
        @(posedge clk) !rstN |-> !outValid;
    endproperty

    resetQuiet_a: assert property (outQuietInReset)
        else $error("outValid high while rstN is low");

    //////////////////////////////////////////////////
    // valid timing
    //////////////////////////////////////////////////

    // capture at edge N, result registered at edge N+1,
    // so the strobe shows two samples after inValid
    property validFollowsInput;
        @(posedge clk) disable iff (!rstN)
            inValid |-> ##2 outValid;
    endproperty

    validFollows_a: assert property (validFollowsInput)
        else $error("inValid was not followed by outValid");

    // no result without an accepted operation
    property noSpuriousValid;
        @(posedge clk) disable iff (!rstN)
            outValid |-> $past(inValid, 2);
    endproperty

    noSpurious_a: assert property (noSpuriousValid)
        else $error("outValid without a matching inValid");

endmodule

// attach to every fpRound instance
bind fpRound fpRoundSva svaChk_i (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .outValid (outValid)
);

// File: verif/fpRoundTb.sv
`timescale 1ns/100ps

module fpRoundTb import roundPkg::*; ();

    logic      clk, rstN, inValid;
    fmtT       outFmt;
    roundModeT roundMode;
    logic      fmaOp, divOp;
    shiftT     corrShifted;
    logic      addendSticky, zZero, invZ;
    expExtT    sumExp, divExp;
    logic      divSticky, divNegSticky, roundSgn;
    logic      outValid;
    fracT      resFrac;
    expT       resExp;
    expExtT    fullResExp;
    logic      sticky, plus1;

    // expected results, one entry per operation in flight
    string     nameQ[$];
    fracT      fracQ[$];
    expExtT    expQ[$];
    logic      stickyQ[$];
    logic      plus1Q[$];
    int        dueQ[$];       // cycle in which outValid must show

    int          opCount, checkCount;
    int          cycleCount;
    logic [31:0] lcgState;
    string       curName;
    fracT        curFrac;
    expExtT      curExp;
    logic        curSticky, curPlus1;
    int          curDue;

    // small-subtract cases, sign picks the direction that shrinks magnitude
    roundModeT smallModes[4] = '{RTZ, RDN, RUP, RNE};
    logic      smallSgn[4]   = '{1'b0, 1'b0, 1'b1, 1'b0};

    fpRound dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // counts rising edges for the latency check
    always @(posedge clk) begin
        cycleCount++;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic shiftT randShift();
        return shiftT'({nextRand(), nextRand(), nextRand(), nextRand()});
    endfunction

    // clear lsb and everything below, then place lsb / round / guard
    function automatic shiftT shapeShift(shiftT base, fmtT fmt, logic lsb, logic rnd, logic grd);
        int    pos;
        int    i;
        shiftT s;
        pos = fmt ? LSB_POS_D : LSB_POS_S;
        s   = base;
        for (i = 0; i <= pos; i++) s[i] = 1'b0;
        s[pos]   = lsb;
        s[pos-1] = rnd;
        s[pos-2] = grd;
        return s;
    endfunction

    task automatic clearFields();
        outFmt       = 1'b1;
        roundMode    = RNE;
        fmaOp        = 1'b0;
        divOp        = 1'b0;
        corrShifted  = '0;
        addendSticky = 1'b0;
        zZero        = 1'b0;
        invZ         = 1'b0;
        sumExp       = '0;
        divExp       = '0;
        divSticky    = 1'b0;
        divNegSticky = 1'b0;
        roundSgn     = 1'b0;
    endtask

    // reference model of the rounding rules, fed from the current inputs
    task automatic predict(input string name);
        int     pos;
        int     i;
        logic   lsb, rnd, grd, below, stk, smallSub, up, down;
        expExtT baseExp;
        addT    word, ulp;
        pos   = outFmt ? LSB_POS_D : LSB_POS_S;
        lsb   = corrShifted[pos];
        rnd   = corrShifted[pos-1];
        grd   = corrShifted[pos-2];
        below = 1'b0;
        for (i = 0; i < pos-2; i++) below = below | corrShifted[i];
        stk   = (fmaOp & (addendSticky | sumExp[EXP_W+1])) | (divOp & divSticky) | below | grd;
        smallSub = !(below || grd) &&
                   ((fmaOp && invZ && !zZero && addendSticky) || (divOp && divNegSticky));
        up    = 1'b0;
        down  = 1'b0;
        case (roundMode)
            RNE: up = rnd && (stk || lsb) && !smallSub;
            RTZ: down = smallSub && !rnd;
            RDN: if (roundSgn) up = !(smallSub && !rnd); else down = smallSub && !rnd;
            RUP: if (!roundSgn) up = !(smallSub && !rnd); else down = smallSub && !rnd;
            RMM: up = rnd && !smallSub;
            default: up = 1'b0;
        endcase
        if (!(stk || rnd)) begin    // exact, nothing to do
            up   = 1'b0;
            down = 1'b0;
        end
        baseExp = divOp ? divExp : sumExp;
        word    = {baseExp, corrShifted[SHIFT_W-1 -: FRAC_W]};
        ulp     = outFmt ? addT'(1) : addT'(1) << (FRAC_W-FRAC1_W);
        if (up)        word = word + ulp;
        else if (down) word = word - ulp;   // borrow runs into the exponent
        nameQ.push_back(name);
        fracQ.push_back(word[FRAC_W-1:0]);
        expQ.push_back(word[ADD_W-1:FRAC_W]);
        stickyQ.push_back(stk);
        plus1Q.push_back(up);
    endtask

    // one strobe, called 0.5 ns after a rising edge
    task automatic issueOp(input string name);
        inValid = 1'b1;
        predict(name);
        dueQ.push_back(cycleCount + 2);   // captured next edge, registered one edge later
        opCount++;
        @(posedge clk);
        #0.5;
    endtask

    task automatic endBurst(input string name);
        int cycles;
        inValid = 1'b0;
        cycles  = 0;
        while (nameQ.size() > 0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (nameQ.size() > 0) begin
            $display("Timed out after 20 cycles waiting for outValid in test %s", name);
            $display("Simulation failed");
            $fatal(1);
        end
        #0.5;
    endtask

    task automatic checkField(input string testName, input string field,
                              input logic [63:0] expVal, input logic [63:0] actVal);
        assert (actVal === expVal) else begin
            $display("Error %s: %s expected %h actual %h", testName, field, expVal, actVal);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // monitor, outputs sampled mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rstN) begin
            assert (outValid === 1'b0) else begin
                $display("outValid went high during reset");
                $display("Simulation failed");
                $fatal(1);
            end
        end else if (outValid === 1'b1) begin
            assert (nameQ.size() > 0) else begin
                $display("outValid pulsed with no operation in flight");
                $display("Simulation failed");
                $fatal(1);
            end
            curName   = nameQ.pop_front();
            curFrac   = fracQ.pop_front();
            curExp    = expQ.pop_front();
            curSticky = stickyQ.pop_front();
            curPlus1  = plus1Q.pop_front();
            curDue    = dueQ.pop_front();
            checkField(curName, "outValid cycle", curDue, cycleCount);
            checkField(curName, "resFrac", curFrac, resFrac);
            checkField(curName, "fullResExp", curExp, fullResExp);
            checkField(curName, "resExp", curExp[EXP_W-1:0], resExp);
            checkField(curName, "sticky", curSticky, sticky);
            checkField(curName, "plus1", curPlus1, plus1);
            checkCount++;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        int          f, op, m, n;
        logic [31:0] r;
        lcgState   = 32'd33;
        opCount    = 0;
        checkCount = 0;
        cycleCount = 0;
        inValid    = 1'b0;
        clearFields();
        rstN = 1'b1;
        #1 rstN = 1'b0;           // falling edge so the async reset is seen
        repeat (4) @(posedge clk);
        #0.5 rstN = 1'b1;
        repeat (3) @(posedge clk);  // idle, no outValid allowed yet
        #0.5;

        // exact values, every mode, both formats and operations
        for (f = 0; f < 2; f++) begin
            for (op = 0; op < 2; op++) begin
                for (m = 0; m < 5; m++) begin
                    r = nextRand();
                    clearFields();
                    outFmt      = fmtT'(f);
                    fmaOp       = (op == 0);
                    divOp       = (op == 1);
                    roundMode   = roundModeT'(m);
                    roundSgn    = r[1];
                    corrShifted = shapeShift(randShift(), outFmt, r[0], 1'b0, 1'b0);
                    sumExp      = {1'b0, r[27:16]};   // no overflow sticky
                    divExp      = expExtT'(nextRand());
                    issueOp("exact");
                end
            end
        end
        endBurst("exact");

        // ties to even, double and single
        for (f = 0; f < 2; f++) begin
            for (n = 0; n < 2; n++) begin
                clearFields();
                outFmt      = fmtT'(f);
                fmaOp       = 1'b1;
                corrShifted = shapeShift(randShift(), outFmt, n[0], 1'b1, 1'b0);
                sumExp      = 13'h0400;
                issueOp("rneTie");
            end
        end
        endBurst("rneTie");

        // subtraction by a small number, fma then divide
        for (op = 0; op < 2; op++) begin
            for (m = 0; m < 4; m++) begin
                r = nextRand();
                clearFields();
                outFmt      = r[1];
                roundMode   = smallModes[m];
                roundSgn    = smallSgn[m];
                fmaOp       = (op == 0);
                divOp       = (op == 1);
                invZ        = (op == 0);
                addendSticky = (op == 0);
                divSticky    = (op == 1);
                divNegSticky = (op == 1);
                corrShifted = shapeShift(randShift(), outFmt, r[0], 1'b0, 1'b0);
                sumExp      = {1'b0, r[27:16]};
                divExp      = {1'b0, r[27:16]};
                issueOp("smallSub");
            end
        end
        endBurst("smallSub");

        // random operands, back to back
        for (n = 0; n < 300; n++) begin
            r = nextRand();
            outFmt       = r[0];
            fmaOp        = r[1];
            divOp        = ~r[1];
            roundSgn     = r[2];
            addendSticky = r[3];
            zZero        = r[4];
            invZ         = r[5];
            divSticky    = r[6];
            divNegSticky = r[7];
            m            = r[31:16] % 5;
            roundMode    = roundModeT'(m);
            corrShifted  = randShift();
            if (r[10:8] == 3'd0)        // sometimes an empty sticky region
                corrShifted = shapeShift(corrShifted, outFmt, r[11], r[12], 1'b0);
            sumExp       = expExtT'(nextRand());
            divExp       = expExtT'(nextRand());
            issueOp("random");
        end
        endBurst("random");

        // all-ones fraction carries into the exponent
        clearFields();
        fmaOp       = 1'b1;
        corrShifted = shapeShift('1, 1'b1, 1'b1, 1'b1, 1'b0);
        sumExp      = 13'h00fe;
        issueOp("carry");
        endBurst("carry");

        if (checkCount == opCount && nameQ.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Checked %0d results for %0d operations", checkCount, opCount);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

// File: src.f
design/roundPkg.sv
design/roundInputStage.sv
design/roundDecision.sv
design/roundOutputStage.sv
design/fpRound.sv
verif/fpRound_sva.sv
verif/fpRoundTb.sv

// File: Bender.yml
package:
  name: fp_round

dependencies: {}

sources:
  # design sources in compile order
  - design/roundPkg.sv
  - design/roundInputStage.sv
  - design/roundDecision.sv
  - design/roundOutputStage.sv
  - design/fpRound.sv

  # verification sources
  - target: test
    files:
      - verif/fpRound_sva.sv
      - verif/fpRoundTb.sv
